/* include/core_params.svh */
/*
	Global widths and instruction encodings for the execute slice
	Data and register widths, opcodes, R-type function codes
*/
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Word and register file geometry
`define DATA_WIDTH     32
`define REG_COUNT      32
`define REG_ADDR_WIDTH 5

// Opcodes, instr[31:27]
`define OPC_RTYPE 5'd0
`define OPC_ADDI  5'd5

// R-type function codes, instr[6:2]
`define FN_ADD 5'd0
`define FN_SUB 5'd1
`define FN_AND 5'd2
`define FN_OR  5'd3
`define FN_SLL 5'd4
`define FN_SRA 5'd5

`endif

/* verilog/core_pkg.sv */
/*
	Shared types for the execute slice
	ALU operation enum, decoded operation record, write-back record
*/
`default_nettype none

`include "core_params.svh"

package core_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_SRA
	} aluOp_e;

	// Held in the execute stage register
	typedef struct packed {
		aluOp_e                     aluOp;
		logic [`REG_ADDR_WIDTH-1:0] srcA;
		logic [`REG_ADDR_WIDTH-1:0] srcB;
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [4:0]                 shamt;
		logic                       useImm;
		logic [`DATA_WIDTH-1:0]     imm;     // sign-extended 17-bit field
		logic                       writes;  // low for r0 or unknown codes
	} decodedOp_t;

	typedef struct packed {
		logic [`REG_ADDR_WIDTH-1:0] dest;
		logic [`DATA_WIDTH-1:0]     data;
		logic                       overflow;
	} wbRecord_t;

endpackage

`default_nettype wire

/* verilog/regFile.sv */
/*
	Register file, 32 x 32 bits
	Two combinational read ports, one clocked write port
	Register 0 is not stored and always reads zero
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module regFile (
	input  wire logic                       clock,
	input  wire logic                       arstN,
	input  wire logic                       writeEnable,
	input  wire logic [`REG_ADDR_WIDTH-1:0] writeAddr,
	input  wire logic [`REG_ADDR_WIDTH-1:0] readAddrA,
	input  wire logic [`REG_ADDR_WIDTH-1:0] readAddrB,
	input  wire logic [`DATA_WIDTH-1:0]     writeData,
	output logic      [`DATA_WIDTH-1:0]     readDataA,
	output logic      [`DATA_WIDTH-1:0]     readDataB
);

	// Storage for registers 1 to 31 only
	logic [`DATA_WIDTH-1:0] regs [1:`REG_COUNT-1];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 1; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeAddr != '0)) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Read muxes, r0 forced to zero
	always_comb begin
		if (readAddrA == '0) begin
			readDataA = '0;
		end else begin
			readDataA = regs[readAddrA];
		end
	end

	always_comb begin
		if (readAddrB == '0) begin
			readDataB = '0;
		end else begin
			readDataB = regs[readAddrB];
		end
	end

endmodule

`default_nettype wire

/* verilog/aluUnit.sv */
/*
	Combinational integer ALU
	add, sub, and, or, sll, sra
	Signed overflow flag for add and sub
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module aluUnit (
	input  wire core_pkg::aluOp_e           aluOp,
	input  wire logic [`DATA_WIDTH-1:0]     opA,
	input  wire logic [`DATA_WIDTH-1:0]     opB,
	input  wire logic [4:0]                 shamt,
	output logic      [`DATA_WIDTH-1:0]     result,
	output logic                            overflow
);

	import core_pkg::*;

	logic signA;
	logic signB;
	logic signR;

	assign signA = opA[`DATA_WIDTH-1];
	assign signB = opB[`DATA_WIDTH-1];
	assign signR = result[`DATA_WIDTH-1];

	always_comb begin
		case (aluOp)
			ALU_ADD: result = opA + opB;
			ALU_SUB: result = opA - opB;
			ALU_AND: result = opA & opB;
			ALU_OR:  result = opA | opB;
			ALU_SLL: result = opA << shamt;
			// Arithmetic shift keeps the sign bit
			ALU_SRA: result = $signed(opA) >>> shamt;
			default: result = '0;
		endcase
	end

	always_comb begin
		case (aluOp)
			// Same-sign operands, result sign flipped
			ALU_ADD: overflow = (signA == signB) && (signR != signA);
			// Opposite-sign operands, result takes subtrahend sign
			ALU_SUB: overflow = (signA != signB) && (signR != signA);
			default: overflow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/execControl.sv */
/*
	Decoder and two-stage sequencer
	Stage one decodes into the operation register
	Stage two reads registers, runs the ALU and writes back
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module execControl (
	input  wire logic                       clock,
	input  wire logic                       arstN,
	input  wire logic                       instrValid,
	input  wire logic [`DATA_WIDTH-1:0]     instr,
	output logic      [`REG_ADDR_WIDTH-1:0] readAddrA,
	output logic      [`REG_ADDR_WIDTH-1:0] readAddrB,
	input  wire logic [`DATA_WIDTH-1:0]     readDataA,
	input  wire logic [`DATA_WIDTH-1:0]     readDataB,
	output logic                            writeEnable,
	output logic      [`REG_ADDR_WIDTH-1:0] writeAddr,
	output logic      [`DATA_WIDTH-1:0]     writeData,
	output core_pkg::aluOp_e                aluOp,
	output logic      [`DATA_WIDTH-1:0]     opA,
	output logic      [`DATA_WIDTH-1:0]     opB,
	output logic      [4:0]                 shamt,
	input  wire logic [`DATA_WIDTH-1:0]     result,
	input  wire logic                       overflow,
	output logic                            wbValid,
	output core_pkg::wbRecord_t             wbOut
);

	import core_pkg::*;

	decodedOp_t decoded;
	decodedOp_t stageOp;
	logic       stageValid;
	logic       known;
	logic [4:0] opcode;
	logic [4:0] funct;

	assign opcode = instr[31:27];
	assign funct  = instr[6:2];

	always_comb begin
		known          = 1'b1;
		decoded.aluOp  = ALU_ADD;
		decoded.dest   = instr[26:22];
		decoded.srcA   = instr[21:17];
		decoded.srcB   = instr[16:12];
		decoded.shamt  = instr[11:7];
		decoded.useImm = 1'b0;
		decoded.imm    = {{(`DATA_WIDTH-17){instr[16]}}, instr[16:0]};
		case (opcode)
			`OPC_RTYPE: begin
				case (funct)
					`FN_ADD: decoded.aluOp = ALU_ADD;
					`FN_SUB: decoded.aluOp = ALU_SUB;
					`FN_AND: decoded.aluOp = ALU_AND;
					`FN_OR:  decoded.aluOp = ALU_OR;
					`FN_SLL: decoded.aluOp = ALU_SLL;
					`FN_SRA: decoded.aluOp = ALU_SRA;
					default: known = 1'b0;
				endcase
			end
			`OPC_ADDI: decoded.useImm = 1'b1;
			default:   known = 1'b0;
		endcase
		decoded.writes = known && (decoded.dest != '0);
	end

	// Stage valid bits
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			stageValid <= 1'b0;
			wbValid    <= 1'b0;
		end else begin
			stageValid <= instrValid;
			wbValid    <= stageValid;
		end
	end

	always_ff @(posedge clock) begin
		if (instrValid) begin
			stageOp <= decoded;
		end
	end

	// Execute stage wiring
	assign readAddrA   = stageOp.srcA;
	assign readAddrB   = stageOp.srcB;
	assign aluOp       = stageOp.aluOp;
	assign opA         = readDataA;
	assign opB         = stageOp.useImm ? stageOp.imm : readDataB;
	assign shamt       = stageOp.shamt;
	assign writeEnable = stageValid && stageOp.writes;
	assign writeAddr   = stageOp.dest;
	assign writeData   = result;

	// Non-writing ops report an all-zero record
	always_ff @(posedge clock) begin
		if (stageValid) begin
			wbOut.dest     <= stageOp.writes ? stageOp.dest : '0;
			wbOut.data     <= stageOp.writes ? result : '0;
			wbOut.overflow <= stageOp.writes && overflow;
		end
	end

endmodule

`default_nettype wire

/* verilog/execCore.sv */
/*
	Top level of the integer execute slice
	Control, register file and ALU
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module execCore (
	input  wire logic                   clock,
	input  wire logic                   arstN,
	input  wire logic                   instrValid,
	input  wire logic [`DATA_WIDTH-1:0] instr,
	output logic                        wbValid,
	output core_pkg::wbRecord_t         wbOut
);

	import core_pkg::*;

	// Register file ports
	logic [`REG_ADDR_WIDTH-1:0] readAddrA;
	logic [`REG_ADDR_WIDTH-1:0] readAddrB;
	logic [`DATA_WIDTH-1:0]     readDataA;
	logic [`DATA_WIDTH-1:0]     readDataB;
	logic                       writeEnable;
	logic [`REG_ADDR_WIDTH-1:0] writeAddr;
	logic [`DATA_WIDTH-1:0]     writeData;

	// ALU ports
	aluOp_e                 aluOp;
	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [4:0]             shamt;
	logic [`DATA_WIDTH-1:0] result;
	logic                   overflow;

	execControl control (.*);

	regFile registers (.*);

	aluUnit alu (.*);

endmodule

`default_nettype wire

/* sim/execCoreTb.sv */
/*
	Testbench for the integer execute slice
	Clock and reset, instructions and expected write-back records from a data file
	Expected-record queue, compare tasks, cycle-count timeout
*/
`timescale 1ns/100ps
`default_nettype none

`include "core_params.svh"

module execCoreTb;

	import core_pkg::*;

	logic                   clock;
	logic                   arstN;
	logic                   instrValid;
	logic [`DATA_WIDTH-1:0] instr;
	logic                   wbValid;
	wbRecord_t              wbOut;

	// Program loaded from the data file
	logic [`DATA_WIDTH-1:0] instrList [$];
	int                     idleList  [$];
	wbRecord_t              expList   [$];

	// Records still owed by the DUT
	wbRecord_t pending [$];
	wbRecord_t expRec;

	// Strobes seen at the last two rising edges
	logic [1:0] validPipe = '0;

	int cycleCount   = 0;
	int timeoutLimit = 0;

	execCore DUT (.*);

	always #2 clock = ~clock;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic checkValid(input logic got, input logic exp);
		if (got !== exp) begin
			abortRun($sformatf("Fail wbValid: got %h, expected %h", got, exp));
		end
	endtask

	task automatic checkWb(input wbRecord_t got, input wbRecord_t exp);
		if (got.dest !== exp.dest) begin
			abortRun($sformatf("Fail wbOut.dest: got %h, expected %h", got.dest, exp.dest));
		end else if (got.data !== exp.data) begin
			abortRun($sformatf("Fail wbOut.data: got %h, expected %h", got.data, exp.data));
		end else if (got.overflow !== exp.overflow) begin
			abortRun($sformatf("Fail wbOut.overflow: got %h, expected %h",
				got.overflow, exp.overflow));
		end
	endtask

	// Each line holds instruction, idle cycles, dest, data and overflow
	task automatic loadStimulus();
		int                         fd;
		int                         n;
		int                         totalCycles;
		string                      line;
		logic [`DATA_WIDTH-1:0]     wordIn;
		int                         idleIn;
		logic [`REG_ADDR_WIDTH-1:0] destIn;
		logic [`DATA_WIDTH-1:0]     dataIn;
		logic                       ovfIn;
		wbRecord_t                  rec;
		totalCycles = 0;
		fd = $fopen("sim/execCoreInput.txt", "r");
		if (fd == 0) begin
			abortRun("Could not open the stimulus file sim/execCoreInput.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%h %d %h %h %h", wordIn, idleIn, destIn, dataIn, ovfIn);
					if (n != 5) begin
						abortRun($sformatf("Malformed stimulus line: %s", line));
					end else begin
						rec.dest     = destIn;
						rec.data     = dataIn;
						rec.overflow = ovfIn;
						instrList.push_back(wordIn);
						idleList.push_back(idleIn);
						expList.push_back(rec);
						totalCycles += 1 + idleIn;
					end
				end
			end
			$fclose(fd);
			timeoutLimit = 16 + totalCycles + 20;
		end
	endtask

	// One strobe per instruction followed by its idle cycles
	task automatic runProgram();
		for (int i = 0; i < instrList.size(); i++) begin
			@(posedge clock);
			#0.5;
			instr      = instrList[i];
			instrValid = 1'b1;
			pending.push_back(expList[i]);
			repeat (idleList[i]) begin
				@(posedge clock);
				#0.5;
				instrValid = 1'b0;
			end
		end
		if (instrValid) begin
			@(posedge clock);
			#0.5;
			instrValid = 1'b0;
		end
	endtask

	always @(posedge clock) begin
		validPipe <= {validPipe[0], instrValid};
	end

	// Outputs sampled away from the rising edge
	always @(negedge clock) begin
		if (arstN) begin
			checkValid(wbValid, validPipe[1]);
			if (wbValid) begin
				if (pending.size() == 0) begin
					abortRun("wbValid was raised with no instruction outstanding");
				end else begin
					expRec = pending.pop_front();
					checkWb(wbOut, expRec);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (timeoutLimit != 0 && cycleCount >= timeoutLimit) begin
			abortRun($sformatf("Timeout after %0d cycles with %0d records outstanding",
				cycleCount, pending.size()));
		end
	end

	initial begin
		clock      = 1'b0;
		arstN      = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		loadStimulus();

		// Reset held for 16 cycles with wbValid low
		repeat (16) begin
			@(negedge clock);
			checkValid(wbValid, 1'b0);
		end
		@(posedge clock);
		#0.5;
		arstN = 1'b1;
		repeat (2) @(negedge clock);

		runProgram();

		// Let the last records drain
		repeat (4) @(negedge clock);
		if (pending.size() != 0) begin
			abortRun($sformatf("%0d write-back records never arrived", pending.size()));
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
verilog/core_pkg.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/execControl.sv
verilog/execCore.sv
sim/execCoreTb.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/core_pkg.sv
      - verilog/regFile.sv
      - verilog/aluUnit.sv
      - verilog/execControl.sv
      - verilog/execCore.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/execCoreTb.sv

/* sim/execCoreInput.txt */
# instr(hex) idle(dec) dest(hex) data(hex) overflow
# expected record is dest 0, data 0, overflow 0 for r0 writes and unknown codes
00420000 1 01 00000000 0
07FE0000 1 1f 00000000 0
28400064 1 01 00000064 0
2881FFF9 0 02 fffffff9 0
28C203E8 1 03 0000044c 0
01022000 1 04 0000005d 0
01443004 2 05 fffffbad 0
01843008 1 06 00000448 0
01C2200C 1 07 fffffffd 0
2A00FFFF 1 08 0000ffff 0
2A410000 1 09 ffff0000 0
02820210 1 0a 00000640 0
02D00810 1 0b ffff0000 0
030E0F90 1 0c 80000000 0
034A0214 1 0d ffffffba 0
03920F94 3 0e ffffffff 0
03D40114 1 0f 00000190 0
040A0014 1 10 fffffbad 0
2C800001 1 12 00000001 0
04592004 0 11 7fffffff 1
04E32000 0 13 80000000 1
05260000 1 14 80000000 0
2D620001 1 15 80000000 1
28020005 1 00 00000000 0
00232000 1 00 00000000 0
05C22018 1 00 00000000 0
062E0000 1 18 00000000 0
18400123 1 00 00000000 0
06420000 1 19 00000064 0
06800000 1 1a 00000000 0
2EC0000A 0 1b 0000000a 0
0737B000 0 1c 00000014 0
0779B004 0 1d 0000000a 0
07BA0190 0 1e 00000050 0
07FC0094 0 1f 00000028 0
06FFC00C 0 1b 0000003c 0
2877FFC4 2 01 00000000 0
